/* flist.f */
hw/mipsTypesPkg.sv
hw/memCtrlPkg.sv
hw/storeAlign.sv
hw/byteMemory.sv
hw/loadExtend.sv
hw/memoryStage.sv
verif/memoryStage_checker.sv
verif/memoryStageTb.sv

/* hw/byteMemory.sv */
`timescale 1ns/1ps

module byteMemory
	import mipsTypesPkg::*, memCtrlPkg::*;
	( input logic clk
	, input wordAddrT wordAddr
	, input laneT lanes
	, input logic writeEnable
	, input wordT wrData
	, output wordT rdData
	);

	byteT rdBytes [laneCount];

	// One byte-wide bank per lane.
	for (genvar lane = 0; lane < laneCount; lane++) begin : laneBank
		byteT bank [memWords];

		always_ff @(posedge clk) begin
			if (writeEnable && lanes[lane]) begin
				bank[wordAddr] <= wrData[lane*byteBits +: byteBits];
			end
		end

		// Read first; a same-cycle write shows up on the next read.
		always_ff @(posedge clk) begin
			rdBytes[lane] <= bank[wordAddr];
		end
	end

	always_comb begin
		for (int lane = 0; lane < laneCount; lane++) begin
			rdData[lane*byteBits +: byteBits] = rdBytes[lane];
		end
	end

endmodule

/* hw/loadExtend.sv */
`timescale 1ns/1ps

module loadExtend
	import mipsTypesPkg::*, memCtrlPkg::*;
	( input logic clk
	, input logic rst
	, input logic reqValid
	, input memCtrlT ctrl
	, input offsetT offset
	, input logic misaligned
	, input wordT rdData
	, output logic respValid
	, output memRespT resp
	);

	logic validQ;
	memCtrlT ctrlQ;
	offsetT offsetQ;
	logic faultQ;
	wordT shifted;
	logic signBit;
	logic fillBit;
	wordT loadData;

	// A beNone request is dropped here and never answered.
	always_ff @(posedge clk) begin
		if (rst) begin
			validQ <= 1'b0;
		end else begin
			validQ <= reqValid && (ctrl.byteEnable != beNone);
		end
	end

	always_ff @(posedge clk) begin
		if (reqValid) begin
			ctrlQ <= ctrl;
			offsetQ <= offset;
			faultQ <= misaligned;
		end
	end

	// Bring the addressed byte down to lane zero.
	always_comb begin
		case (offsetQ)
			2'd1: shifted = rdData >> byteBits;
			2'd2: shifted = rdData >> (2 * byteBits);
			2'd3: shifted = rdData >> (3 * byteBits);
			default: shifted = rdData;
		endcase
	end

	always_comb begin
		case (ctrlQ.byteEnable)
			beByte: signBit = shifted[byteBits-1];
			beHalf: signBit = shifted[halfBits-1];
			default: signBit = 1'b0;
		endcase
	end

	assign fillBit = (ctrlQ.extend == extSigned) && signBit;

	always_comb begin
		case (ctrlQ.byteEnable)
			beByte: loadData = {{(wordBits-byteBits){fillBit}}, shifted[byteBits-1:0]};
			beHalf: loadData = {{(wordBits-halfBits){fillBit}}, shifted[halfBits-1:0]};
			beWord: loadData = shifted;
			default: loadData = '0;
		endcase
	end

	always_comb begin
		resp.fault = faultQ;
		if (ctrlQ.writeEnable || faultQ) begin
			resp.data = '0; // Stores and faults carry no data.
		end else begin
			resp.data = loadData;
		end
	end

	assign respValid = validQ;

endmodule

/* hw/memCtrlPkg.sv */
package memCtrlPkg;

	import mipsTypesPkg::*;

	localparam int laneCount = bytesPerWord;

	typedef logic [laneCount-1:0] laneT; // One bit per byte lane.

	// Base lane masks, before the shift by the byte offset.
	localparam laneT laneNone = 4'b0000;
	localparam laneT laneByte = 4'b0001;
	localparam laneT laneHalf = 4'b0011;
	localparam laneT laneWord = 4'b1111;

	typedef enum logic [1:0] {
		beNone = 2'd0,
		beByte = 2'd1,
		beHalf = 2'd2,
		beWord = 2'd3
	} byteEnableE;

	typedef enum logic {
		extUnsigned = 1'b0,
		extSigned = 1'b1
	} extendE;

	typedef struct packed {
		logic writeEnable;
		byteEnableE byteEnable;
		extendE extend;
	} memCtrlT;

	typedef struct packed {
		memCtrlT ctrl;
		addrT addr;
		wordT data; // Store word, right-aligned.
	} memReqT;

	typedef struct packed {
		wordT data; // Load result, zero for stores and faults.
		logic fault;
	} memRespT;

endpackage

/* hw/memoryStage.sv */
`timescale 1ns/1ps

module memoryStage
	import mipsTypesPkg::*, memCtrlPkg::*;
	( input logic clk
	, input logic rst
	, input logic reqValid
	, input memReqT req
	, output logic respValid
	, output memRespT resp
	);

	laneT lanes;
	wordT wrData;
	logic misaligned;
	wordT rdData;

	storeAlign align_i
		( .req (req)
		, .lanes (lanes)
		, .wrData (wrData)
		, .misaligned (misaligned)
		);

	byteMemory mem_i
		( .clk (clk)
		, .wordAddr (req.addr[addrW-1:offsetW])
		, .lanes (lanes)
		, .writeEnable (reqValid && req.ctrl.writeEnable)
		, .wrData (wrData)
		, .rdData (rdData)
		);

	loadExtend ext_i
		( .clk (clk)
		, .rst (rst)
		, .reqValid (reqValid)
		, .ctrl (req.ctrl)
		, .offset (req.addr[offsetW-1:0])
		, .misaligned (misaligned)
		, .rdData (rdData)
		, .respValid (respValid)
		, .resp (resp)
		);

endmodule

/* hw/mipsTypesPkg.sv */
package mipsTypesPkg;

	// Data widths of the datapath.
	localparam int wordBits = 32;
	localparam int halfBits = 16;
	localparam int byteBits = 8;
	localparam int bytesPerWord = wordBits / byteBits;

	// Memory geometry.
	localparam int memWords = 64;
	localparam int offsetW = $clog2(bytesPerWord); // Byte offset inside a word.
	localparam int wordAddrW = $clog2(memWords);
	localparam int addrW = wordAddrW + offsetW; // Byte address, 8 bits.

	typedef logic [wordBits-1:0] wordT;
	typedef logic [byteBits-1:0] byteT;

	typedef logic [addrW-1:0] addrT;
	typedef logic [wordAddrW-1:0] wordAddrT;
	typedef logic [offsetW-1:0] offsetT;

endpackage

/* hw/storeAlign.sv */
`timescale 1ns/1ps

module storeAlign
	import mipsTypesPkg::*, memCtrlPkg::*;
	( input memReqT req
	, output laneT lanes
	, output wordT wrData
	, output logic misaligned
	);

	offsetT offset;
	laneT baseLanes;
	wordT baseData;
	laneT shiftedLanes;
	wordT shiftedData;
	logic halfOdd;
	logic wordOffset;

	assign offset = req.addr[offsetW-1:0];

	// Lane mask and data for an access at offset zero.
	always_comb begin
		case (req.ctrl.byteEnable)
			beByte: begin
				baseLanes = laneByte;
				baseData = {{(wordBits-byteBits){1'b0}}, req.data[byteBits-1:0]};
			end
			beHalf: begin
				baseLanes = laneHalf;
				baseData = {{(wordBits-halfBits){1'b0}}, req.data[halfBits-1:0]};
			end
			beWord: begin
				baseLanes = laneWord;
				baseData = req.data;
			end
			default: begin
				baseLanes = laneNone;
				baseData = '0;
			end
		endcase
	end

	// Move lanes and data up to the addressed byte.
	always_comb begin
		case (offset)
			2'd1: begin
				shiftedLanes = laneT'(baseLanes << 1);
				shiftedData = baseData << byteBits;
			end
			2'd2: begin
				shiftedLanes = laneT'(baseLanes << 2);
				shiftedData = baseData << (2 * byteBits);
			end
			2'd3: begin
				shiftedLanes = laneT'(baseLanes << 3);
				shiftedData = baseData << (3 * byteBits);
			end
			default: begin
				shiftedLanes = baseLanes;
				shiftedData = baseData;
			end
		endcase
	end

	assign halfOdd = (req.ctrl.byteEnable == beHalf) && offset[0];
	assign wordOffset = (req.ctrl.byteEnable == beWord) && (offset != '0);
	assign misaligned = halfOdd || wordOffset;

	always_comb begin
		if (misaligned) begin
			lanes = laneNone; // Nothing reaches the memory.
			wrData = '0;
		end else begin
			lanes = shiftedLanes;
			wrData = shiftedData;
		end
	end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Builds the memory stage testbench with Verilator and runs it.
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f flist.f \
	--top-module memoryStageTb -Mdir obj_dir; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/VmemoryStageTb 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "all tests passed"; then
	exit 0
fi

echo "Pass message not found in simulation output"
exit 1

/* verif/memoryStageTb.sv */
`timescale 1ns/1ps

module memoryStageTb
	import mipsTypesPkg::*, memCtrlPkg::*;
	();

	localparam int memBytes = memWords * bytesPerWord;
	localparam int expectedCycles = 2000; // Roughly the traffic of all five tests.
	localparam int timeoutCycles = expectedCycles * 5 / 2;
	localparam int randomCount = 1200;

	logic clk = 1'b0;
	logic rst;
	logic reqValid;
	memReqT req;
	logic respValid;
	memRespT resp;

	int seed;
	int cycles = 0;
	byteT shadow [memBytes]; // Reference copy of the memory, byte addressed.
	memRespT expected [$];

	memoryStage dut_i
		( .clk (clk)
		, .rst (rst)
		, .reqValid (reqValid)
		, .req (req)
		, .respValid (respValid)
		, .resp (resp)
		);

	always #2 clk = ~clk;

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("tests failed");
		$fatal(1, "Simulation stopped on error.");
	endtask

	task automatic check(input string name, input wordT got, input wordT want);
		if (got !== want) begin
			$display("FAIL at %0t: %s is %h, expected %h", $time, name, got, want);
			abortRun("Response does not match the reference model.");
		end
	endtask

	function automatic logic misalignedReq(input memReqT r);
		return ((r.ctrl.byteEnable == beHalf) && r.addr[0])
			|| ((r.ctrl.byteEnable == beWord) && (r.addr[1:0] != 2'b00));
	endfunction

	// Expected response, worked out from the shadow bytes.
	function automatic memRespT refResp(input memReqT r);
		memRespT rsp;
		wordT v;
		int a;
		rsp = '0;
		v = '0;
		a = int'(r.addr);
		if (misalignedReq(r)) begin
			rsp.fault = 1'b1;
		end else if (!r.ctrl.writeEnable) begin
			case (r.ctrl.byteEnable)
				beByte: begin
					v[7:0] = shadow[a];
					if (r.ctrl.extend == extSigned && v[7]) v[31:8] = '1;
				end
				beHalf: begin
					v[15:0] = {shadow[a+1], shadow[a]};
					if (r.ctrl.extend == extSigned && v[15]) v[31:16] = '1;
				end
				beWord: v = {shadow[a+3], shadow[a+2], shadow[a+1], shadow[a]};
				default: v = '0;
			endcase
			rsp.data = v;
		end
		return rsp;
	endfunction

	task automatic applyStore(input memReqT r);
		int n;
		case (r.ctrl.byteEnable)
			beByte: n = 1;
			beHalf: n = 2;
			beWord: n = 4;
			default: n = 0;
		endcase
		if (r.ctrl.writeEnable && !misalignedReq(r)) begin
			for (int i = 0; i < n; i++) begin
				shadow[int'(r.addr) + i] = r.data[8*i +: 8];
			end
		end
	endtask

	task automatic issue(input memReqT r);
		@(posedge clk);
		reqValid <= 1'b1;
		req <= r;
		if (r.ctrl.byteEnable != beNone) expected.push_back(refResp(r));
		applyStore(r); // After refResp, so the model sees memory as it was.
	endtask

	task automatic access(input logic we, input byteEnableE be, input extendE ex,
		input addrT a, input wordT d);
		memReqT r;
		r.ctrl.writeEnable = we;
		r.ctrl.byteEnable = be;
		r.ctrl.extend = ex;
		r.addr = a;
		r.data = d;
		issue(r);
	endtask

	task automatic issueRandom();
		wordT r;
		wordT d;
		r = $random(seed);
		d = $random(seed);
		access(r[0], byteEnableE'(r[2:1]), extendE'(r[3]), addrT'(r[15:8]), d);
	endtask

	// Responses are sampled on the falling edge, away from the DUT's updates.
	always @(negedge clk) begin : compareResp
		memRespT want;
		if (!rst) begin
			if (respValid) begin
				if (expected.size() == 0) begin
					abortRun("A response arrived with no request pending.");
				end else begin
					want = expected.pop_front();
					check("resp.data", resp.data, want.data);
					check("resp.fault", wordT'(resp.fault), wordT'(want.fault));
				end
			end
			if (expected.size() > 1) abortRun("An expected response never arrived.");
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= timeoutCycles) abortRun("Timeout, the run did not finish in time.");
	end

	initial begin : stimulus
		int w;
		int off;
		wordT d;
		seed = 25901;
		rst = 1'b1;
		reqValid = 1'b0;
		req = '0;
		repeat (10) @(posedge clk);
		rst <= 1'b0;

		for (w = 0; w < memWords; w++) begin
			d = $random(seed);
			access(1'b1, beWord, extUnsigned, addrT'(w * 4), d);
		end
		for (w = 0; w < memWords; w++) access(1'b0, beWord, extUnsigned, addrT'(w * 4), '0);

		for (w = 0; w < 32; w++) begin // Bytes into words 0..15, halves into 16..31.
			for (off = 0; off < 4; off++) begin
				d = $random(seed);
				if (w < 16) begin
					access(1'b1, beByte, extUnsigned, addrT'(w * 4 + off), d);
					access(1'b0, beWord, extUnsigned, addrT'(w * 4), '0); // Other lanes kept.
				end else if (off[0] == 1'b0) begin
					access(1'b1, beHalf, extUnsigned, addrT'(w * 4 + off), d);
					access(1'b0, beWord, extUnsigned, addrT'(w * 4), '0);
				end
			end
		end
		for (w = 0; w < 32; w++) access(1'b0, beWord, extUnsigned, addrT'(w * 4), '0);

		access(1'b1, beWord, extUnsigned, addrT'(32 * 4), 32'h807F_FF01);
		access(1'b1, beWord, extUnsigned, addrT'(33 * 4), 32'h017F_80FF);
		for (w = 0; w < 34; w++) begin
			for (off = 0; off < 4; off++) begin
				access(1'b0, beByte, extSigned, addrT'(w * 4 + off), '0);
				access(1'b0, beByte, extUnsigned, addrT'(w * 4 + off), '0);
				if (off[0] == 1'b0) begin
					access(1'b0, beHalf, extSigned, addrT'(w * 4 + off), '0);
					access(1'b0, beHalf, extUnsigned, addrT'(w * 4 + off), '0);
				end
			end
		end

		for (w = 40; w < 48; w++) begin
			for (off = 1; off < 4; off++) begin
				d = $random(seed);
				if (off[0]) access(1'b1, beHalf, extUnsigned, addrT'(w * 4 + off), d);
				access(1'b1, beWord, extUnsigned, addrT'(w * 4 + off), d);
				access(1'b0, beWord, extSigned, addrT'(w * 4 + off), '0);
			end
			access(1'b1, beNone, extUnsigned, addrT'(w * 4), 32'hDEAD_BEEF);
			access(1'b0, beWord, extUnsigned, addrT'(w * 4), '0);
		end

		repeat (randomCount) issueRandom();

		@(posedge clk);
		reqValid <= 1'b0;
		repeat (3) @(posedge clk);
		if (expected.size() != 0) begin
			abortRun("Responses were still missing at the end of the run.");
		end else begin
			$display("all tests passed");
			$finish;
		end
	end

endmodule

/* verif/memoryStage_checker.sv */
`timescale 1ns/1ps

module memoryStage_checker
	import mipsTypesPkg::*, memCtrlPkg::*;
	( input logic clk
	, input logic rst
	, input logic reqValid
	, input memReqT req
	, input logic respValid
	, input memRespT resp
	);

	// No response leaves the stage while reset is held.
	assert property (@(posedge clk) rst |=> !respValid)
		else $error("respValid high during reset");

	assert property (@(posedge clk) disable iff (rst)
		(reqValid && req.ctrl.byteEnable != beNone) |=> respValid)
		else $error("request was not answered one cycle later");

	// Covers beNone too.
	assert property (@(posedge clk) disable iff (rst)
		respValid |-> $past(reqValid && req.ctrl.byteEnable != beNone))
		else $error("respValid without a matching request");

	assert property (@(posedge clk) disable iff (rst)
		(respValid && resp.fault) |-> (resp.data == '0))
		else $error("faulted response carries data");

endmodule

bind memoryStage memoryStage_checker checker_i (.*);
